// File: design/core_pkg.sv
// Core widths, sizes, opcode encoding and slot state encoding
`default_nettype none

package core_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////////////////////

    // Reservation station slots, also the source's starting credit count
    localparam int NUM_SLOTS = 4;
    // Architectural registers
    localparam int NUM_REGS  = 8;
    localparam int DATA_W    = 16;
    // Tag names the producing slot
    localparam int TAG_W     = $clog2(NUM_SLOTS);
    localparam int REG_W     = $clog2(NUM_REGS);

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    // Operand or result value
    typedef logic [DATA_W-1:0] data_t;
    // Architectural register index
    typedef logic [REG_W-1:0]  reg_idx_t;
    // Slot index of a pending producer
    typedef logic [TAG_W-1:0]  tag_t;

    // Opcodes, LI takes its result from the immediate
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_XOR = 2'd2,
        OP_LI  = 2'd3
    } op_t;

    // Slot life cycle
    typedef enum logic [1:0] {
        SLOT_FREE  = 2'd0,
        SLOT_WAIT  = 2'd1,
        SLOT_READY = 2'd2,
        SLOT_DONE  = 2'd3
    } slot_state_t;

endpackage

`default_nettype wire

// File: design/dispatch_unit.sv
// Register file, map table, source operand read with CDB bypass and free slot choice
`timescale 1ns/10ps
`default_nettype none

module dispatch_unit (
    input  logic                              clock,
    input  logic                              reset,
    // Incoming instruction
    input  logic                              inst_valid,
    input  core_pkg::op_t                     inst_op,
    input  core_pkg::reg_idx_t                inst_dest,
    input  core_pkg::reg_idx_t                inst_src_a,
    input  core_pkg::reg_idx_t                inst_src_b,
    input  core_pkg::data_t                   inst_imm,
    // Slot occupancy
    input  logic [core_pkg::NUM_SLOTS-1:0]    slot_busy,
    // Common data bus
    input  logic                              cdb_valid,
    input  core_pkg::tag_t                    cdb_tag,
    input  core_pkg::data_t                   cdb_value,
    // Architectural read port
    input  core_pkg::reg_idx_t                rd_idx,
    // Allocation to slots
    output logic [core_pkg::NUM_SLOTS-1:0]    alloc,
    output core_pkg::op_t                     alloc_op,
    output core_pkg::data_t                   alloc_val_a,
    output core_pkg::data_t                   alloc_val_b,
    output core_pkg::tag_t                    alloc_tag_a,
    output core_pkg::tag_t                    alloc_tag_b,
    output logic                              alloc_wait_a,
    output logic                              alloc_wait_b,
    output core_pkg::data_t                   rd_data
);

    // Architectural values
    core_pkg::data_t                   regs    [core_pkg::NUM_REGS];
    // Map table, pending flag plus producer tag per register
    logic [core_pkg::NUM_REGS-1:0]     pending;
    core_pkg::tag_t                    map_tag [core_pkg::NUM_REGS];

    core_pkg::tag_t                    free_tag;
    logic                              free_any;
    logic                              do_alloc;

    ////////////////////////////////////////////////////////////////////////////
    // Source operand resolution
    ////////////////////////////////////////////////////////////////////////////

    // Register value, same-cycle broadcast, or pending tag
    function automatic void resolve_src(
        input  core_pkg::reg_idx_t src,
        output core_pkg::data_t    val,
        output core_pkg::tag_t     tag,
        output logic               wait_flag
    );
        logic hit;
        hit       = pending[src] && cdb_valid && (cdb_tag == map_tag[src]);
        tag       = map_tag[src];
        wait_flag = pending[src] && !hit;
        // Bypass beats the stale register copy
        val       = hit ? cdb_value : regs[src];
    endfunction

    always_comb begin
        resolve_src(inst_src_a, alloc_val_a, alloc_tag_a, alloc_wait_a);
        resolve_src(inst_src_b, alloc_val_b, alloc_tag_b, alloc_wait_b);
        // Load immediate ignores both sources
        if (inst_op == core_pkg::OP_LI) begin
            alloc_val_a  = inst_imm;
            alloc_val_b  = '0;
            alloc_wait_a = 1'b0;
            alloc_wait_b = 1'b0;
        end
    end

    assign alloc_op = inst_op;

    ////////////////////////////////////////////////////////////////////////////
    // Slot selection
    ////////////////////////////////////////////////////////////////////////////

    // Lowest numbered free slot wins, scan downward so the last hit is lowest
    always_comb begin
        free_tag = '0;
        free_any = 1'b0;
        for (int i = core_pkg::NUM_SLOTS - 1; i >= 0; i--) begin
            if (!slot_busy[i]) begin
                free_tag = core_pkg::tag_t'(i);
                free_any = 1'b1;
            end
        end
    end

    assign do_alloc = inst_valid && free_any;

    // One-hot allocate strobe
    always_comb begin
        for (int i = 0; i < core_pkg::NUM_SLOTS; i++) begin
            alloc[i] = do_alloc && (free_tag == core_pkg::tag_t'(i));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register file and map table update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            pending <= '0;
            for (int r = 0; r < core_pkg::NUM_REGS; r++) begin
                regs[r]    <= '0;
                map_tag[r] <= '0;
            end
        end else begin
            // Write back only where the register still waits on this tag
            if (cdb_valid) begin
                for (int r = 0; r < core_pkg::NUM_REGS; r++) begin
                    if (pending[r] && (map_tag[r] == cdb_tag)) begin
                        regs[r]    <= cdb_value;
                        pending[r] <= 1'b0;
                    end
                end
            end
            // Rename comes last so it overrides a same-cycle clear
            if (do_alloc) begin
                pending[inst_dest] <= 1'b1;
                map_tag[inst_dest] <= free_tag;
            end
        end
    end

    // Committed state only, no bypass
    assign rd_data = regs[rd_idx];

endmodule

`default_nettype wire

// File: design/rs_slot.sv
// One reservation station entry with operand capture, CDB snoop and ALU
`timescale 1ns/10ps
`default_nettype none

module rs_slot (
    input  logic                 clock,
    input  logic                 reset,
    // Allocation from dispatch
    input  logic                 alloc,
    input  core_pkg::op_t        alloc_op,
    input  core_pkg::data_t      alloc_val_a,
    input  core_pkg::data_t      alloc_val_b,
    input  core_pkg::tag_t       alloc_tag_a,
    input  core_pkg::tag_t       alloc_tag_b,
    input  logic                 alloc_wait_a,
    input  logic                 alloc_wait_b,
    // Arbiter grant for this slot
    input  logic                 grant,
    // Common data bus
    input  logic                 cdb_valid,
    input  core_pkg::tag_t       cdb_tag,
    input  core_pkg::data_t      cdb_value,
    output logic                 busy,
    output logic                 done,
    output core_pkg::data_t      result
);

    core_pkg::slot_state_t  state;

    // Captured instruction
    core_pkg::op_t          op;
    core_pkg::data_t        val_a;
    core_pkg::data_t        val_b;
    core_pkg::tag_t         tag_a;
    core_pkg::tag_t         tag_b;
    logic                   wait_a;
    logic                   wait_b;

    logic                   take;
    logic                   snoop_a;
    logic                   snoop_b;
    core_pkg::data_t        alu_out;

    // Accept only into an empty entry
    assign take    = alloc && (state == core_pkg::SLOT_FREE);

    // Broadcast matches a missing operand
    assign snoop_a = wait_a && cdb_valid && (cdb_tag == tag_a);
    assign snoop_b = wait_b && cdb_valid && (cdb_tag == tag_b);

    ////////////////////////////////////////////////////////////////////////////
    // Slot FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state  <= core_pkg::SLOT_FREE;
            wait_a <= 1'b0;
            wait_b <= 1'b0;
        end else begin
            case (state)
                core_pkg::SLOT_FREE: begin
                    if (take) begin
                        wait_a <= alloc_wait_a;
                        wait_b <= alloc_wait_b;
                        state  <= (alloc_wait_a || alloc_wait_b) ? core_pkg::SLOT_WAIT
                                                                 : core_pkg::SLOT_READY;
                    end
                end
                core_pkg::SLOT_WAIT: begin
                    wait_a <= wait_a && !snoop_a;
                    wait_b <= wait_b && !snoop_b;
                    // Both present after this edge
                    if ((!wait_a || snoop_a) && (!wait_b || snoop_b)) begin
                        state <= core_pkg::SLOT_READY;
                    end
                end
                // Result register loads on this edge
                core_pkg::SLOT_READY: state <= core_pkg::SLOT_DONE;
                // Hold until the arbiter takes it
                core_pkg::SLOT_DONE: begin
                    if (grant) begin
                        state <= core_pkg::SLOT_FREE;
                    end
                end
                default: state <= core_pkg::SLOT_FREE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Operands and result
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (take) begin
            op    <= alloc_op;
            val_a <= alloc_val_a;
            val_b <= alloc_val_b;
            tag_a <= alloc_tag_a;
            tag_b <= alloc_tag_b;
        end else if (state == core_pkg::SLOT_WAIT) begin
            if (snoop_a) begin
                val_a <= cdb_value;
            end
            if (snoop_b) begin
                val_b <= cdb_value;
            end
        end
        if (state == core_pkg::SLOT_READY) begin
            result <= alu_out;
        end
    end

    // 16-bit wrapping arithmetic
    always_comb begin
        case (op)
            core_pkg::OP_ADD: alu_out = val_a + val_b;
            core_pkg::OP_SUB: alu_out = val_a - val_b;
            core_pkg::OP_XOR: alu_out = val_a ^ val_b;
            default:          alu_out = val_a;
        endcase
    end

    assign busy = (state != core_pkg::SLOT_FREE);
    assign done = (state == core_pkg::SLOT_DONE);

endmodule

`default_nettype wire

// File: design/cdb_arbiter.sv
// Round-robin CDB arbiter with registered broadcast and credit return
`timescale 1ns/10ps
`default_nettype none

module cdb_arbiter (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [core_pkg::NUM_SLOTS-1:0]    done,
    input  core_pkg::data_t                   result [core_pkg::NUM_SLOTS],
    output logic [core_pkg::NUM_SLOTS-1:0]    grant,
    output logic                              cdb_valid,
    output core_pkg::tag_t                    cdb_tag,
    output core_pkg::data_t                   cdb_value,
    output logic                              credit_return
);

    // Search starts here, one past the last winner
    core_pkg::tag_t  rr_ptr;
    core_pkg::tag_t  winner;
    logic            found;

    ////////////////////////////////////////////////////////////////////////////
    // Winner search
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        core_pkg::tag_t idx;
        winner = '0;
        found  = 1'b0;
        for (int i = 0; i < core_pkg::NUM_SLOTS; i++) begin
            // Tag width wraps the index around the ring
            idx = core_pkg::tag_t'(rr_ptr + core_pkg::tag_t'(i));
            if (!found && done[idx]) begin
                winner = idx;
                found  = 1'b1;
            end
        end
    end

    // One-hot grant, slot frees itself on the next edge
    always_comb begin
        for (int i = 0; i < core_pkg::NUM_SLOTS; i++) begin
            grant[i] = found && (winner == core_pkg::tag_t'(i));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Broadcast register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            rr_ptr        <= '0;
            cdb_valid     <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            cdb_valid     <= found;
            // Freed slot hands a credit back
            credit_return <= found;
            if (found) begin
                rr_ptr <= winner + 1'b1;
            end
        end
    end

    // Payload follows cdb_valid
    always_ff @(posedge clock) begin
        cdb_tag   <= winner;
        cdb_value <= result[winner];
    end

endmodule

`default_nettype wire

// File: design/tomasulo_core.sv
// Top level with dispatch unit, reservation station slots and CDB arbiter
`timescale 1ns/10ps
`default_nettype none

module tomasulo_core (
    input  logic                 clock,
    input  logic                 reset,
    // Instruction source
    input  logic                 inst_valid,
    input  core_pkg::op_t        inst_op,
    input  core_pkg::reg_idx_t   inst_dest,
    input  core_pkg::reg_idx_t   inst_src_a,
    input  core_pkg::reg_idx_t   inst_src_b,
    input  core_pkg::data_t      inst_imm,
    output logic                 credit_return,
    // Broadcast, visible outside for checking
    output logic                 cdb_valid,
    output core_pkg::tag_t       cdb_tag,
    output core_pkg::data_t      cdb_value,
    // Final state read
    input  core_pkg::reg_idx_t   rd_idx,
    output core_pkg::data_t      rd_data
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////////////////////////////////////////

    logic [core_pkg::NUM_SLOTS-1:0]  alloc;
    logic [core_pkg::NUM_SLOTS-1:0]  slot_busy;
    logic [core_pkg::NUM_SLOTS-1:0]  slot_done;
    logic [core_pkg::NUM_SLOTS-1:0]  grant;
    core_pkg::data_t                 slot_result [core_pkg::NUM_SLOTS];

    // Shared allocation bus, qualified per slot by alloc
    core_pkg::op_t                   alloc_op;
    core_pkg::data_t                 alloc_val_a;
    core_pkg::data_t                 alloc_val_b;
    core_pkg::tag_t                  alloc_tag_a;
    core_pkg::tag_t                  alloc_tag_b;
    logic                            alloc_wait_a;
    logic                            alloc_wait_b;

    dispatch_unit dispatch (
        .clock        (clock),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst_op      (inst_op),
        .inst_dest    (inst_dest),
        .inst_src_a   (inst_src_a),
        .inst_src_b   (inst_src_b),
        .inst_imm     (inst_imm),
        .slot_busy    (slot_busy),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value),
        .rd_idx       (rd_idx),
        .alloc        (alloc),
        .alloc_op     (alloc_op),
        .alloc_val_a  (alloc_val_a),
        .alloc_val_b  (alloc_val_b),
        .alloc_tag_a  (alloc_tag_a),
        .alloc_tag_b  (alloc_tag_b),
        .alloc_wait_a (alloc_wait_a),
        .alloc_wait_b (alloc_wait_b),
        .rd_data      (rd_data)
    );

    // Slot position is its tag
    for (genvar g = 0; g < core_pkg::NUM_SLOTS; g++) begin : gen_slot
        rs_slot slot (
            .clock        (clock),
            .reset        (reset),
            .alloc        (alloc[g]),
            .alloc_op     (alloc_op),
            .alloc_val_a  (alloc_val_a),
            .alloc_val_b  (alloc_val_b),
            .alloc_tag_a  (alloc_tag_a),
            .alloc_tag_b  (alloc_tag_b),
            .alloc_wait_a (alloc_wait_a),
            .alloc_wait_b (alloc_wait_b),
            .grant        (grant[g]),
            .cdb_valid    (cdb_valid),
            .cdb_tag      (cdb_tag),
            .cdb_value    (cdb_value),
            .busy         (slot_busy[g]),
            .done         (slot_done[g]),
            .result       (slot_result[g])
        );
    end

    cdb_arbiter arbiter (
        .clock         (clock),
        .reset         (reset),
        .done          (slot_done),
        .result        (slot_result),
        .grant         (grant),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .credit_return (credit_return)
    );

endmodule

`default_nettype wire

// File: tests/tomasulo_core_asserts.sv
// Concurrent checks on slot occupancy at dispatch, CDB grant and outputs after reset
`timescale 1ns/10ps
`default_nettype none

module tomasulo_core_asserts (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              inst_valid,
    input  logic [core_pkg::NUM_SLOTS-1:0]    slot_busy,
    input  logic [core_pkg::NUM_SLOTS-1:0]    grant,
    input  logic                              cdb_valid,
    input  logic                              credit_return
);

    // Source must hold a credit, so some slot is free
    a_alloc_free: assert property (@(posedge clock) disable iff (reset)
        inst_valid |-> !(&slot_busy))
        else $error("instruction offered while every slot is busy");

    // Single CDB, so only last cycle's granted slot may go free
    a_one_grant: assert property (@(posedge clock) disable iff (reset)
        ($past(slot_busy) & ~slot_busy) == $past(grant))
        else $error("freed slots differ from the single grant of the previous cycle");

    // Broadcast register and credit pulse start cleared
    a_quiet_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> (!cdb_valid && !credit_return))
        else $error("broadcast or credit active in the first cycle after reset");

endmodule

// Dispatch inputs and arbiter outputs as seen at the top level
bind tomasulo_core tomasulo_core_asserts core_checks (
    .clock         (clock),
    .reset         (reset),
    .inst_valid    (inst_valid),
    .slot_busy     (slot_busy),
    .grant         (grant),
    .cdb_valid     (cdb_valid),
    .credit_return (credit_return)
);

`default_nettype wire

// File: tests/tomasulo_core_tb.sv
// Testbench for the Tomasulo core with credit-limited source, in-order model and checks
`timescale 1ns/10ps
`default_nettype none

module tomasulo_core_tb;

    localparam string VECTOR_FILE     = "tests/core_vectors.txt";
    localparam int    MEM_WORDS       = 64;
    localparam int    SEED_INIT       = 32'h3684_c531;
    localparam int    CYCLES_PER_INST = 8;
    localparam int    TIMEOUT_MARGIN  = 100;

    logic                  clock      = 1'b0;
    logic                  reset      = 1'b1;
    logic                  inst_valid = 1'b0;
    core_pkg::op_t         inst_op    = core_pkg::OP_ADD;
    core_pkg::reg_idx_t    inst_dest  = '0;
    core_pkg::reg_idx_t    inst_src_a = '0;
    core_pkg::reg_idx_t    inst_src_b = '0;
    core_pkg::data_t       inst_imm   = '0;
    core_pkg::reg_idx_t    rd_idx     = '0;
    logic                  credit_return;
    logic                  cdb_valid;
    core_pkg::tag_t        cdb_tag;
    core_pkg::data_t       cdb_value;
    core_pkg::data_t       rd_data;

    // Word 0 count, then instructions, then expected r0..r7
    logic [31:0]           vectors [MEM_WORDS];

    // In-order reference state and per-slot expected broadcast
    core_pkg::data_t                 model_regs  [core_pkg::NUM_REGS] = '{default: '0};
    core_pkg::data_t                 slot_expect [core_pkg::NUM_SLOTS] = '{default: '0};
    logic [core_pkg::NUM_SLOTS-1:0]  slot_used    = '0;
    int                              seed         = SEED_INIT;
    int                              num_inst     = 0;
    int                              sent         = 0;
    int                              credits      = core_pkg::NUM_SLOTS;
    int                              cdb_count    = 0;
    int                              return_count = 0;
    int                              cycles       = 0;
    int                              cycle_limit  = 0;

    always #4 clock = ~clock;

    tomasulo_core UUT (
        .clock         (clock),
        .reset         (reset),
        .inst_valid    (inst_valid),
        .inst_op       (inst_op),
        .inst_dest     (inst_dest),
        .inst_src_a    (inst_src_a),
        .inst_src_b    (inst_src_b),
        .inst_imm      (inst_imm),
        .credit_return (credit_return),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .rd_idx        (rd_idx),
        .rd_data       (rd_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "Stopping at the first failed check");
    endtask

    task automatic check_data(input string name, input core_pkg::data_t expected,
                              input core_pkg::data_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected 0x%h, actual 0x%h",
                                name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            abort_run($sformatf("ERROR %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    // Value an instruction produces given sources read in program order
    function automatic core_pkg::data_t model_result(input core_pkg::op_t op,
                                                     input core_pkg::data_t a,
                                                     input core_pkg::data_t b,
                                                     input core_pkg::data_t imm);
        case (op)
            core_pkg::OP_ADD: return a + b;
            core_pkg::OP_SUB: return a - b;
            core_pkg::OP_XOR: return a ^ b;
            default:          return imm;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Per-cycle monitor and source
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        logic [31:0]      word;
        core_pkg::data_t  expect_val;
        int               slot;
        int               gap;
        if (!reset) begin
            cycles++;
            if (cycles > cycle_limit) begin
                abort_run($sformatf("Timeout after %0d cycles, %0d of %0d instructions sent",
                                    cycles, sent, num_inst));
            end
            // Slot behind this broadcast went free on the previous edge
            if (cdb_valid) begin
                cdb_count++;
                if (!slot_used[cdb_tag]) begin
                    abort_run($sformatf("CDB broadcast from slot %0d, which holds nothing",
                                        cdb_tag));
                end
                check_data($sformatf("cdb value from slot %0d", cdb_tag),
                           slot_expect[cdb_tag], cdb_value);
                slot_used[cdb_tag] = 1'b0;
            end
            if (credit_return) begin
                return_count++;
                credits++;
            end
            // Instruction driven last edge enters the lowest free slot now
            if (inst_valid) begin
                slot = -1;
                for (int s = core_pkg::NUM_SLOTS - 1; s >= 0; s--) begin
                    if (!slot_used[s]) begin
                        slot = s;
                    end
                end
                if (slot < 0) begin
                    abort_run("Instruction sent while the model shows every slot busy");
                end
                expect_val = model_result(inst_op, model_regs[inst_src_a],
                                          model_regs[inst_src_b], inst_imm);
                slot_expect[slot]     = expect_val;
                slot_used[slot]       = 1'b1;
                model_regs[inst_dest] = expect_val;
            end
            inst_valid <= 1'b0;
            if (sent < num_inst && credits > 0) begin
                gap = $random(seed) % 4;
                // Opening burst back to back, random idles afterwards
                if (sent < core_pkg::NUM_SLOTS || gap != 0) begin
                    word = vectors[1 + sent];
                    inst_valid <= 1'b1;
                    inst_op    <= core_pkg::op_t'(word[29:28]);
                    inst_dest  <= word[26:24];
                    inst_src_a <= word[22:20];
                    inst_src_b <= word[18:16];
                    inst_imm   <= word[15:0];
                    sent++;
                    credits--;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        $readmemh(VECTOR_FILE, vectors);
        num_inst = int'(vectors[0]);
        if (num_inst < 1 || num_inst + 1 + core_pkg::NUM_REGS > MEM_WORDS) begin
            abort_run("Vector file is missing or holds a bad instruction count");
        end
        cycle_limit = num_inst * CYCLES_PER_INST + TIMEOUT_MARGIN;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        // Drain until every instruction is sent and has broadcast
        do begin
            @(negedge clock);
        end while (sent != num_inst || cdb_count < num_inst);
        repeat (2) @(posedge clock);
        check_count("cdb pulses", num_inst, cdb_count);
        check_count("credit returns", num_inst, return_count);
        check_count("credits after last broadcast", core_pkg::NUM_SLOTS, credits);
        // Final architectural state through the read port
        for (int r = 0; r < core_pkg::NUM_REGS; r++) begin
            @(posedge clock);
            rd_idx <= core_pkg::reg_idx_t'(r);
            @(negedge clock);
            check_data($sformatf("r%0d against in-order model", r), model_regs[r], rd_data);
            check_data($sformatf("r%0d against vector file", r),
                       vectors[1 + num_inst + r][15:0], rd_data);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
design/core_pkg.sv
design/dispatch_unit.sv
design/rs_slot.sv
design/cdb_arbiter.sv
design/tomasulo_core.sv
tests/tomasulo_core_asserts.sv
tests/tomasulo_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the Tomasulo core testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --assert -f build.f --top-module tomasulo_core_tb \
        -Mdir "$OBJ_DIR" -o sim_tomasulo > "$BUILD_LOG" 2>&1; then
    cat "$BUILD_LOG"
    echo "Verilator build returned an error"
    exit 1
fi

"./$OBJ_DIR/sim_tomasulo" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$SIM_LOG"; then
    exit 0
fi
echo "Pass line not found in $SIM_LOG"
exit 1

// File: tests/core_vectors.txt
// Word 0 is the instruction count, then one instruction per word, then r0..r7 expected
// Instruction word: [29:28] op (0 add, 1 sub, 2 xor, 3 li), [26:24] dest, [22:20] src a, [18:16] src b, [15:0] imm
0000001e
31000011 // li  r1, 0x0011
32000022 // li  r2, 0x0022
33000033 // li  r3, 0x0033
34000044 // li  r4, 0x0044
05120000 // add r5, r1, r2
06550000 // add r6, r5, r5
17630000 // sub r7, r6, r3
01760000 // add r1, r7, r6
12140000 // sub r2, r1, r4
03210000 // add r3, r2, r1  slow writer of r3
33001234 // li  r3, 0x1234  fast writer of r3
00340000 // add r0, r3, r4
3400fff0 // li  r4, 0xfff0
35000020 // li  r5, 0x0020
06450000 // add r6, r4, r5  wraps
17540000 // sub r7, r5, r4  wraps
31000001 // li  r1, 0x0001
12150000 // sub r2, r1, r5  wraps
23240000 // xor r3, r2, r4
20070000 // xor r0, r0, r7
25550000 // xor r5, r5, r5
14510000 // sub r4, r5, r1
06640000 // add r6, r6, r4
27430000 // xor r7, r4, r3
3100a5a5 // li  r1, 0xa5a5
21100000 // xor r1, r1, r0
02210000 // add r2, r2, r1
13320000 // sub r3, r3, r2
05230000 // add r5, r2, r3  slow writer of r5
35000bad // li  r5, 0x0bad  last writer of r5
// Expected final registers r0..r7
00001248
0000b7ed
0000b7ce
00004843
0000ffff
00000bad
0000000f
0000ffee
